/* logic/pool_pkg.sv */
package pool_pkg;

	// Activation word
	localparam int WORD_W = 16;

	// Channel lanes per atom
	localparam int LANES = 8;

	// Window holds up to 2**MAX_WINDOW_LOG2 atoms
	localparam int MAX_WINDOW_LOG2 = 3;

	// Sum of a full window never overflows
	localparam int ACC_W = WORD_W + MAX_WINDOW_LOG2;

	localparam int FIFO_DEPTH = 4; // Atoms in the buffer

	typedef enum logic {
		POOL_MAX, // Lane maximum
		POOL_AVG  // Floor of lane average
	} pool_op_t;

	// One signed activation
	typedef logic signed [WORD_W-1:0] word_t;

	// One word per channel lane, lane 0 first from the source
	typedef word_t [LANES-1:0] atom_t;

endpackage

/* logic/atom_if.sv */
`timescale 1ns/100ps

interface atom_if #(
	parameter int p_lanes = pool_pkg::LANES
);

	logic valid; // Atom and tags are held
	logic ready; // Consumer takes the atom this cycle

	pool_pkg::word_t [p_lanes-1:0] atom; // Lane 0 is the first word received

	logic window_end; // Last atom of a pooling window
	logic run_end;    // Last atom of the run

	// Producer side
	modport src (
		output valid, atom, window_end, run_end,
		input  ready
	);

	// Consumer side
	modport dst (
		input  valid, atom, window_end, run_end,
		output ready
	);

endinterface

/* logic/atom_packer.sv */
`timescale 1ns/100ps

module atom_packer #(
	parameter int p_lanes = pool_pkg::LANES
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            i_start,
	input  logic            i_busy,        // Pool unit still owns a run
	input  logic [1:0]      i_window_log2,
	input  logic [15:0]     i_outputs,     // Result atoms in the run
	input  logic            i_in_valid,
	input  pool_pkg::word_t i_in_data,
	output logic            o_in_ready,
	atom_if.src             out
);

	localparam int LANE_W = $clog2(p_lanes);
	localparam int CNT_W = pool_pkg::MAX_WINDOW_LOG2;

	logic run_q;                 // Still taking words for this run
	logic [LANE_W-1:0] lane_cnt; // Next lane to fill
	logic [CNT_W-1:0] atom_cnt;  // Atom index inside the window
	logic [CNT_W-1:0] atom_last;
	logic [1:0] log2_q;
	logic [15:0] win_left;       // Windows still to send
	logic valid_q;
	logic wend_q;
	logic rend_q;
	pool_pkg::word_t [p_lanes-1:0] atom_q;
	logic word_take;
	logic atom_full;
	logic win_full;

	// Window size minus one
	assign atom_last = CNT_W'((1 << log2_q) - 1);

	assign atom_full = (lane_cnt == LANE_W'(p_lanes - 1)); // Word completes the atom
	assign win_full = (atom_cnt == atom_last);            // Atom completes the window

	// Stall while the held atom is refused, and after the run's last word
	assign o_in_ready = run_q && (!valid_q || out.ready);
	assign word_take = i_in_valid && o_in_ready;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			run_q <= 1'b0;
			valid_q <= 1'b0;
			lane_cnt <= '0;
			atom_cnt <= '0;
			win_left <= '0;
		end else begin
			if (valid_q && out.ready)
				valid_q <= 1'b0; // Buffer took the atom
			if (i_start && !i_busy) begin
				run_q <= 1'b1; // Ready rises next cycle
				lane_cnt <= '0;
				atom_cnt <= '0;
				win_left <= i_outputs;
			end else if (word_take) begin
				if (atom_full) begin
					lane_cnt <= '0;
					valid_q <= 1'b1; // Atom visible the cycle after its last word
					atom_cnt <= win_full ? '0 : atom_cnt + 1'b1;
					if (win_full) begin
						win_left <= win_left - 1'b1;
						if (win_left == 16'd1)
							run_q <= 1'b0; // Nothing more to take
					end
				end else begin
					lane_cnt <= lane_cnt + 1'b1;
				end
			end
		end
	end

	// Atom payload and its tags
	always_ff @(posedge clk) begin
		if (i_start && !i_busy)
			log2_q <= i_window_log2;
		if (word_take) begin
			atom_q <= {i_in_data, atom_q[p_lanes-1:1]}; // After p_lanes shifts first word sits in lane 0
			if (atom_full) begin
				wend_q <= win_full;
				rend_q <= win_full && (win_left == 16'd1);
			end
		end
	end

	assign out.valid = valid_q;
	assign out.atom = atom_q;
	assign out.window_end = wend_q;
	assign out.run_end = rend_q;

endmodule

/* logic/atom_fifo.sv */
`timescale 1ns/100ps

module atom_fifo #(
	parameter int p_fifo_depth = pool_pkg::FIFO_DEPTH
) (
	input logic clk,
	input logic rst,
	input logic i_start, // Flushes the queue between runs
	atom_if.dst push,
	atom_if.src pop
);

	localparam int PTR_W = (p_fifo_depth > 1) ? $clog2(p_fifo_depth) : 1;
	localparam int CNT_W = $clog2(p_fifo_depth + 1);

	// Circular storage of tagged atoms
	pool_pkg::atom_t mem_atom [p_fifo_depth];
	logic mem_wend [p_fifo_depth];
	logic mem_rend [p_fifo_depth];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // Occupancy
	logic run_open;          // Atoms of a run pass through
	logic do_push;
	logic do_pop;
	logic flush;

	// Wrap also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(p_fifo_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign push.ready = (count != CNT_W'(p_fifo_depth)); // Full stalls the packer
	assign pop.valid = (count != '0);

	// Head of the queue
	assign pop.atom = mem_atom[rd_ptr];
	assign pop.window_end = mem_wend[rd_ptr];
	assign pop.run_end = mem_rend[rd_ptr];

	assign do_push = push.valid && push.ready;
	assign do_pop = pop.valid && pop.ready;

	// A start during a run is ignored downstream, so keep the queue then
	assign flush = i_start && !run_open;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			run_open <= 1'b0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ; // Both or neither keep the count
			endcase
			if (do_pop && pop.run_end)
				run_open <= 1'b0; // Last atom handed over
			else if (do_push)
				run_open <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem_atom[wr_ptr] <= push.atom;
			mem_wend[wr_ptr] <= push.window_end;
			mem_rend[wr_ptr] <= push.run_end;
		end
	end

endmodule

/* logic/pool_unit.sv */
`timescale 1ns/100ps

module pool_unit #(
	parameter int p_lanes = pool_pkg::LANES
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,
	input  pool_pkg::pool_op_t i_op,
	input  logic [1:0]         i_window_log2,
	atom_if.dst                in,
	output logic               o_out_valid,
	output pool_pkg::word_t    o_out_data,
	output logic               o_busy,
	output logic               o_done
);

	localparam int LANE_W = $clog2(p_lanes);
	localparam int ACC_W = pool_pkg::ACC_W;
	localparam int WORD_W = pool_pkg::WORD_W;

	logic busy_q;                // Start to done
	logic done_q;
	logic first_q;               // Next atom opens a window
	logic ser_q;                 // Writing the result atom out
	logic [LANE_W-1:0] ser_cnt;  // Lane on the output
	logic last_q;                // Result belongs to the run_end window
	pool_pkg::pool_op_t op_q;
	logic [1:0] log2_q;
	logic take;

	// Running values per lane
	pool_pkg::word_t run_max [p_lanes];
	logic signed [ACC_W-1:0] run_sum [p_lanes];

	// Values after the atom being taken
	pool_pkg::word_t next_max [p_lanes];
	logic signed [ACC_W-1:0] next_sum [p_lanes];
	logic signed [ACC_W-1:0] avg_sh [p_lanes];

	pool_pkg::word_t [p_lanes-1:0] result_q;

	assign in.ready = busy_q && !ser_q; // No atoms while serializing
	assign take = in.valid && in.ready;

	always_comb begin
		for (int l = 0; l < p_lanes; l++) begin
			if (first_q) begin
				next_max[l] = in.atom[l]; // Window opens with this atom
				next_sum[l] = $signed(in.atom[l]);
			end else begin
				next_max[l] = ($signed(in.atom[l]) > $signed(run_max[l])) ?
					in.atom[l] : run_max[l];
				next_sum[l] = run_sum[l] + $signed(in.atom[l]);
			end
			// Power of two window, floor division by arithmetic shift
			avg_sh[l] = next_sum[l] >>> log2_q;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			first_q <= 1'b1;
			ser_q <= 1'b0;
			ser_cnt <= '0;
			last_q <= 1'b0;
		end else begin
			done_q <= 1'b0; // Single cycle pulse
			if (i_start && !busy_q) begin
				busy_q <= 1'b1;
				first_q <= 1'b1;
			end
			if (take) begin
				first_q <= in.window_end;
				if (in.window_end) begin
					ser_q <= 1'b1; // Lane 0 goes out next cycle
					ser_cnt <= '0;
					last_q <= in.run_end;
				end
			end
			if (ser_q) begin
				ser_cnt <= ser_cnt + 1'b1;
				if (ser_cnt == LANE_W'(p_lanes - 1)) begin
					ser_q <= 1'b0;
					if (last_q) begin
						busy_q <= 1'b0; // Falls with the done pulse
						done_q <= 1'b1;
					end
				end
			end
		end
	end

	// Run settings and datapath
	always_ff @(posedge clk) begin
		if (i_start && !busy_q) begin
			op_q <= i_op;
			log2_q <= i_window_log2;
		end
		if (take) begin
			for (int l = 0; l < p_lanes; l++) begin
				run_max[l] <= next_max[l];
				run_sum[l] <= next_sum[l];
				if (in.window_end)
					result_q[l] <= (op_q == pool_pkg::POOL_MAX) ?
						next_max[l] : avg_sh[l][WORD_W-1:0]; // Average fits one word
			end
		end
	end

	assign o_out_valid = ser_q;
	assign o_out_data = result_q[ser_cnt];
	assign o_busy = busy_q;
	assign o_done = done_q;

endmodule

/* logic/pool_engine.sv */
`timescale 1ns/100ps

module pool_engine #(
	parameter int p_lanes = pool_pkg::LANES,
	parameter int p_fifo_depth = pool_pkg::FIFO_DEPTH
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_start,       // Pulse, taken while not busy
	input  pool_pkg::pool_op_t i_op,
	input  logic [1:0]         i_window_log2,
	input  logic [15:0]        i_outputs,     // Result atoms per run
	input  logic               i_in_valid,
	input  pool_pkg::word_t    i_in_data,
	output logic               o_in_ready,
	output logic               o_out_valid,   // One pulse per result word
	output pool_pkg::word_t    o_out_data,
	output logic               o_busy,
	output logic               o_done
);

	// Packer to buffer
	atom_if #(.p_lanes(p_lanes)) packed_bus ();

	// Buffer to pooling unit
	atom_if #(.p_lanes(p_lanes)) pool_bus ();

	atom_packer #(
		.p_lanes(p_lanes)
	) u_packer (
		.clk(clk),
		.rst(rst),
		.i_start(i_start),
		.i_busy(o_busy),       // Blocks a restart mid-run
		.i_window_log2(i_window_log2),
		.i_outputs(i_outputs),
		.i_in_valid(i_in_valid),
		.i_in_data(i_in_data),
		.o_in_ready(o_in_ready),
		.out(packed_bus.src)
	);

	atom_fifo #(
		.p_fifo_depth(p_fifo_depth)
	) u_fifo (
		.clk(clk),
		.rst(rst),
		.i_start(i_start),
		.push(packed_bus.dst),
		.pop(pool_bus.src)
	);

	pool_unit #(
		.p_lanes(p_lanes)
	) u_pool (
		.clk(clk),
		.rst(rst),
		.i_start(i_start),
		.i_op(i_op),
		.i_window_log2(i_window_log2),
		.in(pool_bus.dst),
		.o_out_valid(o_out_valid),
		.o_out_data(o_out_data),
		.o_busy(o_busy),
		.o_done(o_done)
	);

endmodule

/* bench/pool_engine_checker.sv */
`timescale 1ns/100ps

module pool_engine_checker #(
	parameter int p_lanes = pool_pkg::LANES
) (
	input logic                       clk,
	input logic                       rst,
	input logic                       i_start,
	input logic                       i_in_valid,
	input logic                       o_in_ready,
	input logic                       o_out_valid,
	input logic                       o_busy,
	input logic                       o_done,
	input logic [$clog2(p_lanes)-1:0] lane_cnt // Packer fill position
);

	// Result words and the done pulse never overlap
	assert property (@(posedge clk) disable iff (rst) !(o_out_valid && o_done))
		else $error("Output word together with done");

	assert property (@(posedge clk) disable iff (rst) o_done |=> !o_done)
		else $error("Done longer than one cycle");

	// A refused strobe leaves the packer where it was
	assert property (@(posedge clk) disable iff (rst)
		(i_in_valid && !o_in_ready && !i_start) |=> $stable(lane_cnt))
		else $error("Input word taken while not ready");

	// Second cycle of reset onward, all controls quiet
	assert property (@(posedge clk) (rst && $past(rst)) |->
		(!o_in_ready && !o_out_valid && !o_busy && !o_done))
		else $error("Control output high during reset");

endmodule

bind pool_engine pool_engine_checker #(.p_lanes(p_lanes)) u_checker (
	.clk(clk),
	.rst(rst),
	.i_start(i_start),
	.i_in_valid(i_in_valid),
	.o_in_ready(o_in_ready),
	.o_out_valid(o_out_valid),
	.o_busy(o_busy),
	.o_done(o_done),
	.lane_cnt(u_packer.lane_cnt)
);

/* bench/pool_engine_tb.sv */
`timescale 1ns/100ps

module pool_engine_tb;

	localparam int LANES = pool_pkg::LANES;
	localparam int WAIT_MAX = 2000; // Cycles before a wait gives up

	logic clk;
	logic rst;
	logic i_start;
	pool_pkg::pool_op_t i_op;
	logic [1:0] i_window_log2;
	logic [15:0] i_outputs;
	logic i_in_valid;
	pool_pkg::word_t i_in_data;
	logic o_in_ready;
	logic o_out_valid;
	pool_pkg::word_t o_out_data;
	logic o_busy;
	logic o_done;

	pool_pkg::word_t stim [0:1023]; // Words of the current run in send order
	logic [31:0] lfsr_state;
	pool_pkg::pool_op_t cur_op;
	int cur_log2;
	int out_cnt;    // Result words seen this run
	int exp_words;  // Result words the run must give
	int done_cnt;
	int errors;
	int tests_run;
	int tests_failed;
	logic ready_fell; // A word waited on o_in_ready mid-run
	bit timed_out;

	pool_engine uut (
		.clk(clk), .rst(rst), .i_start(i_start), .i_op(i_op),
		.i_window_log2(i_window_log2), .i_outputs(i_outputs),
		.i_in_valid(i_in_valid), .i_in_data(i_in_data),
		.o_in_ready(o_in_ready), .o_out_valid(o_out_valid),
		.o_out_data(o_out_data), .o_busy(o_busy), .o_done(o_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Galois LFSR, taps 32 30 26 25
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state); // One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	// Expected word for one window and lane, from the stored input
	function automatic pool_pkg::word_t ref_word(input pool_pkg::pool_op_t op, input int log2,
		input int win, input int lane);
		int n;
		int sum;
		pool_pkg::word_t w;
		pool_pkg::word_t mx;
		n = 1 << log2;
		sum = 0;
		mx = '0;
		for (int a = 0; a < n; a++) begin
			w = stim[(win * n + a) * LANES + lane];
			if (a == 0 || w > mx)
				mx = w;
			sum = sum + w; // Sign extended
		end
		if (op == pool_pkg::POOL_MAX)
			return mx;
		return pool_pkg::word_t'(sum >>> log2); // Floor division
	endfunction

	// Compares every result word as it leaves the DUT
	always @(posedge clk) begin
		if (!rst) begin
			if (o_out_valid) begin
				if (o_out_data !== ref_word(cur_op, cur_log2, out_cnt / LANES, out_cnt % LANES)) begin
					$display("Mismatch at %0t: window %0d lane %0d got %0d expected %0d", $time,
						out_cnt / LANES, out_cnt % LANES, $signed(o_out_data),
						$signed(ref_word(cur_op, cur_log2, out_cnt / LANES, out_cnt % LANES)));
					errors++;
				end
				out_cnt++;
			end
			if (o_done) begin
				if (out_cnt != exp_words) begin
					$display("Mismatch at %0t: done after %0d words, expected %0d", $time,
						out_cnt, exp_words);
					errors++;
				end
				done_cnt++;
			end
		end
	end

	task automatic stop_failed(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$finish;
	endtask

	// A wait that ran out, later waits are skipped
	task automatic note_timeout(input string msg);
		$display("%s", msg);
		errors++;
		timed_out = 1'b1;
	endtask

	// One clock edge, start is a single pulse
	task automatic tick();
		@(posedge clk);
		i_start <= 1'b0;
	endtask

	task automatic fill_stim(input int total, input int log2, input bit neg_first);
		logic [31:0] v;
		for (int i = 0; i < total; i++) begin
			rand_bits(16, v);
			stim[i] = pool_pkg::word_t'(v[15:0]);
			if (neg_first && i < LANES * (1 << log2))
				stim[i][15] = 1'b1; // First window all negative
		end
	endtask

	// Holds each word until the DUT shows ready on an edge
	task automatic send_words(input int total, input bit gaps, input bit extra_start);
		logic [31:0] g;
		int t;
		for (int idx = 0; idx < total && !timed_out; idx++) begin
			if (gaps) begin
				rand_bits(2, g);
				i_in_valid <= 1'b0;
				repeat (g) tick();
			end
			i_in_valid <= 1'b1;
			i_in_data <= stim[idx];
			tick();
			t = 0;
			while (!o_in_ready && t < WAIT_MAX) begin
				ready_fell = 1'b1; // Word held back before the run's end
				tick();
				t++;
			end
			if (t >= WAIT_MAX)
				note_timeout($sformatf("Input word %0d never accepted", idx));
			if (extra_start && idx == 2 * LANES) begin
				i_start <= 1'b1; // Must be ignored mid-run
				i_op <= (cur_op == pool_pkg::POOL_MAX) ? pool_pkg::POOL_AVG : pool_pkg::POOL_MAX;
				i_outputs <= 16'd1;
			end
		end
		i_in_valid <= 1'b0;
	endtask

	task automatic run_test(input string name, input pool_pkg::pool_op_t op, input int log2,
		input int outputs, input bit gaps, input bit extra_start, input bit need_stall);
		int errs_before;
		int total;
		int t;
		errs_before = errors;
		total = outputs * (1 << log2) * LANES;
		cur_op = op;
		cur_log2 = log2;
		fill_stim(total, log2, op == pool_pkg::POOL_MAX);
		out_cnt = 0;
		exp_words = outputs * LANES;
		done_cnt = 0;
		ready_fell = 1'b0;
		tick();
		i_start <= 1'b1;
		i_op <= op;
		i_window_log2 <= log2[1:0];
		i_outputs <= outputs[15:0];
		tick();
		send_words(total, gaps, extra_start);
		t = 0;
		while (!timed_out && done_cnt == 0 && t < WAIT_MAX) begin
			tick();
			t++;
		end
		if (t >= WAIT_MAX)
			note_timeout($sformatf("%s: done never came", name));
		if (o_busy) begin
			$display("%s: busy still high with done at %0t", name, $time);
			errors++;
		end
		repeat (LANES + 2) tick(); // Quiet time, nothing more may appear
		if (out_cnt != outputs * LANES || done_cnt != 1) begin
			$display("Mismatch at %0t: %s gave %0d words and %0d done pulses, expected %0d and 1",
				$time, name, out_cnt, done_cnt, outputs * LANES);
			errors++;
		end
		if (need_stall && !ready_fell) begin
			$display("%s: input ready never held back a word", name);
			errors++;
		end
		tests_run++;
		if (errors != errs_before)
			tests_failed++;
		$display("Test %s: %s", name, (errors == errs_before) ? "ok" : "failed");
	endtask

	initial begin
		rst = 1'b1;
		i_start = 1'b0;
		i_op = pool_pkg::POOL_MAX;
		i_window_log2 = 2'd0;
		i_outputs = 16'd0;
		i_in_valid = 1'b0;
		i_in_data = '0;
		lfsr_state = 32'd97845;
		cur_op = pool_pkg::POOL_MAX;
		cur_log2 = 0;
		out_cnt = 0;
		exp_words = 0;
		done_cnt = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		ready_fell = 1'b0;
		timed_out = 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		run_test("max_window4", pool_pkg::POOL_MAX, 2, 3, 1'b0, 1'b0, 1'b0);
		run_test("avg_window8", pool_pkg::POOL_AVG, 3, 2, 1'b0, 1'b0, 1'b0);
		run_test("max_window1", pool_pkg::POOL_MAX, 0, 2, 1'b0, 1'b0, 1'b0);
		run_test("avg_window1", pool_pkg::POOL_AVG, 0, 2, 1'b0, 1'b0, 1'b0);
		run_test("gaps_long_run", pool_pkg::POOL_AVG, 1, 6, 1'b1, 1'b0, 1'b0);
		// Output of one atom takes a cycle longer than its input, so the buffer fills
		run_test("fifo_full", pool_pkg::POOL_MAX, 0, 48, 1'b0, 1'b0, 1'b1);
		run_test("restart_ignored", pool_pkg::POOL_MAX, 1, 3, 1'b0, 1'b1, 1'b0);
		run_test("fresh_run", pool_pkg::POOL_AVG, 2, 2, 1'b1, 1'b0, 1'b0);
		$display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Guard against a stuck run
	initial begin
		#500000;
		stop_failed("Simulation time limit reached");
	end

endmodule

/* pool_engine.f */
logic/pool_pkg.sv
logic/atom_if.sv
logic/atom_packer.sv
logic/atom_fifo.sv
logic/pool_unit.sv
logic/pool_engine.sv
bench/pool_engine_checker.sv
bench/pool_engine_tb.sv

/* Makefile */
TOP = pool_engine_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f pool_engine.f -o sim
	@out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
